//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --assert -j 0
TOP       = mem_access_tb
FILELIST  = mem_access.f
BUILD_DIR = obj_dir
LOG       = sim.log
SIM_ARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/mem_access_checker.sv
`timescale 1ns/10ps

module mem_access_checker #(
    parameter int DATA_WIDTH = mem_bus_pkg::default_data_width
) (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    mem_request,
    input logic                    mem_write,
    input logic [DATA_WIDTH/8-1:0] mem_byte_en,
    input logic                    exception_valid,
    input logic                    mem_read_valid,
    input logic                    load_valid
);
    // Number of failed assertions so far
    int assert_fails = 0;

    write_needs_request: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write |-> mem_request)
        else begin
            $error("mem_write high without mem_request");
            assert_fails++;
        end

    no_request_on_exception: assert property (@(posedge clk) disable iff (!rst_n)
        !(exception_valid && mem_request))
        else begin
            $error("exception_valid and mem_request high together");
            assert_fails++;
        end

    strobes_need_request: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_request |-> (mem_byte_en == '0))
        else begin
            $error("mem_byte_en nonzero without mem_request");
            assert_fails++;
        end

    // Load result one cycle behind the read data
    load_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid == $past(mem_read_valid))
        else begin
            $error("load_valid does not follow mem_read_valid by one cycle");
            assert_fails++;
        end

endmodule

bind mem_access_unit mem_access_checker #(.DATA_WIDTH(DATA_WIDTH)) chk_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .mem_request    (mem_request),
    .mem_write      (mem_write),
    .mem_byte_en    (mem_byte_en),
    .exception_valid(exception_valid),
    .mem_read_valid (mem_read_valid),
    .load_valid     (load_valid)
);

//--- bench/mem_access_stimulus.txt
# op funct3 addr store_data read_data  exp_byte_en exp_bus_data exp_load_data exp_exc exp_code
# all hex, op 1 is a store; bus data and load data are 0 where they are not checked
1 0 1000 1122334455667788 0000000000000000 01 1122334455667788 0000000000000000 0 0
1 0 1005 1122334455667788 0000000000000000 20 6677880000000000 0000000000000000 0 0
1 1 1002 1122334455667788 0000000000000000 0c 3344556677880000 0000000000000000 0 0
1 2 1004 1122334455667788 0000000000000000 f0 5566778800000000 0000000000000000 0 0
1 3 1008 1122334455667788 0000000000000000 ff 1122334455667788 0000000000000000 0 0
1 1 1001 1122334455667788 0000000000000000 00 0000000000000000 0000000000000000 1 6
1 2 1006 1122334455667788 0000000000000000 00 0000000000000000 0000000000000000 1 6
0 3 1004 0000000000000000 81f263d4a53647e8 00 0000000000000000 0000000000000000 1 4
1 4 1000 1122334455667788 0000000000000000 00 0000000000000000 0000000000000000 1 6
0 7 1000 0000000000000000 81f263d4a53647e8 00 0000000000000000 0000000000000000 1 4
0 0 2000 0000000000000000 81f263d4a53647e8 01 0000000000000000 ffffffffffffffe8 0 0
0 0 2005 0000000000000000 81f263d4a53647e8 20 0000000000000000 0000000000000063 0 0
0 1 2002 0000000000000000 81f263d4a53647e8 0c 0000000000000000 ffffffffffffa536 0 0
0 2 2000 0000000000000000 81f263d4a53647e8 0f 0000000000000000 ffffffffa53647e8 0 0
0 2 2004 0000000000000000 81f263d4a53647e8 f0 0000000000000000 ffffffff81f263d4 0 0
0 3 2008 0000000000000000 81f263d4a53647e8 ff 0000000000000000 81f263d4a53647e8 0 0
0 4 2000 0000000000000000 81f263d4a53647e8 01 0000000000000000 00000000000000e8 0 0
0 5 2006 0000000000000000 81f263d4a53647e8 c0 0000000000000000 00000000000081f2 0 0
0 6 2004 0000000000000000 81f263d4a53647e8 f0 0000000000000000 0000000081f263d4 0 0

//--- bench/mem_access_tb.sv
`timescale 1ns/10ps

module mem_access_tb;

    localparam int data_width = mem_bus_pkg::default_data_width;
    localparam int addr_width = mem_bus_pkg::default_addr_width;
    localparam int lanes      = data_width / 8;
    localparam int clk_period = 100;
    localparam int max_tests  = 64;

    logic                                  clk = 1'b0;
    logic                                  rst_n;
    logic                                  req_valid;
    logic                                  req_write;
    logic [rv_isa_pkg::funct3_width-1:0]   funct3;
    logic [addr_width-1:0]                 req_addr;
    logic [data_width-1:0]                 req_data;
    logic                                  mem_request;
    logic                                  mem_write;
    logic [addr_width-1:0]                 mem_addr;
    logic [lanes-1:0]                      mem_byte_en;
    logic [data_width-1:0]                 mem_data;
    logic                                  mem_read_valid = 1'b0;
    logic [data_width-1:0]                 mem_read_data = '0;
    logic                                  exception_valid;
    logic [rv_isa_pkg::exc_code_width-1:0] exception_code;
    logic                                  load_valid;
    logic [data_width-1:0]                 load_data;

    // Memory model state
    logic                  read_pending = 1'b0;
    logic [data_width-1:0] mem_word = '0;

    // One entry per line of the stimulus file
    logic                                  v_write [max_tests];
    logic [rv_isa_pkg::funct3_width-1:0]   v_funct3[max_tests];
    logic [addr_width-1:0]                 v_addr  [max_tests];
    logic [data_width-1:0]                 v_sdata [max_tests];
    logic [data_width-1:0]                 v_rdata [max_tests];
    logic [lanes-1:0]                      v_be    [max_tests];
    logic [data_width-1:0]                 v_bus   [max_tests];
    logic [data_width-1:0]                 v_load  [max_tests];
    logic                                  v_exc   [max_tests];
    logic [rv_isa_pkg::exc_code_width-1:0] v_code  [max_tests];

    int   n_tests = 0;
    int   errors = 0;
    int   failed_tests = 0;
    logic loaded = 1'b0;

    mem_access_unit #(
        .DATA_WIDTH(data_width),
        .ADDR_WIDTH(addr_width)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .funct3         (funct3),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .mem_request    (mem_request),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_byte_en    (mem_byte_en),
        .mem_data       (mem_data),
        .mem_read_valid (mem_read_valid),
        .mem_read_data  (mem_read_data),
        .exception_valid(exception_valid),
        .exception_code (exception_code),
        .load_valid     (load_valid),
        .load_data      (load_data)
    );

    always #(clk_period / 2) clk = ~clk;

    // Answers a load two cycles after mem_request
    always @(posedge clk) begin
        read_pending   <= mem_request && !mem_write;
        mem_read_valid <= read_pending;
        if (read_pending) begin
            mem_read_data <= mem_word;
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic read_vectors;
        int    fd;
        int    rc;
        string line;
        fd = $fopen("bench/mem_access_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < max_tests) begin
                rc = $fgets(line, fd);
                if (rc == 0) break;
                // Comment lines do not scan and are dropped here
                rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                             v_write[n_tests], v_funct3[n_tests], v_addr[n_tests],
                             v_sdata[n_tests], v_rdata[n_tests], v_be[n_tests],
                             v_bus[n_tests], v_load[n_tests], v_exc[n_tests],
                             v_code[n_tests]);
                if (rc == 10) n_tests++;
            end
            $fclose(fd);
        end
        loaded = 1'b1;
    endtask

    task automatic check_idle;
        if (mem_request !== 1'b0) report_mismatch("mem_request", 64'(mem_request), 64'(0));
        if (mem_write !== 1'b0) report_mismatch("mem_write", 64'(mem_write), 64'(0));
        if (exception_valid !== 1'b0) begin
            report_mismatch("exception_valid", 64'(exception_valid), 64'(0));
        end
        if (load_valid !== 1'b0) report_mismatch("load_valid", 64'(load_valid), 64'(0));
    endtask

    task automatic run_access(input int i);
        int   errors_before;
        int   waited;
        logic legal;
        legal = !v_exc[i];
        errors_before = errors;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= v_write[i];
        funct3    <= v_funct3[i];
        req_addr  <= v_addr[i];
        req_data  <= v_sdata[i];
        mem_word  <= v_rdata[i];
        @(posedge clk);
        req_valid <= 1'b0;
        // Bus outputs and exception live in the cycle after the request edge
        @(negedge clk);
        if (mem_request !== legal) report_mismatch("mem_request", 64'(mem_request), 64'(legal));
        if (mem_write !== (legal && v_write[i])) begin
            report_mismatch("mem_write", 64'(mem_write), 64'(legal && v_write[i]));
        end
        if (exception_valid !== v_exc[i]) begin
            report_mismatch("exception_valid", 64'(exception_valid), 64'(v_exc[i]));
        end
        if (v_exc[i] && exception_code !== v_code[i]) begin
            report_mismatch("exception_code", 64'(exception_code), 64'(v_code[i]));
        end
        if (mem_byte_en !== v_be[i]) begin
            report_mismatch("mem_byte_en", 64'(mem_byte_en), 64'(v_be[i]));
        end
        if (legal && mem_addr !== v_addr[i]) report_mismatch("mem_addr", mem_addr, v_addr[i]);
        if (legal && v_write[i] && mem_data !== v_bus[i]) begin
            report_mismatch("mem_data", mem_data, v_bus[i]);
        end
        if (legal && !v_write[i]) begin
            waited = 0;
            while (!load_valid && waited < 8) begin
                @(negedge clk);
                waited++;
            end
            if (!load_valid) begin
                $display("error at %0t: load_valid never arrived for test %0d", $time, i);
                errors++;
            end else if (load_data !== v_load[i]) begin
                report_mismatch("load_data", load_data, v_load[i]);
            end
        end
        @(negedge clk);
        check_idle();
        if (errors == errors_before) begin
            $display("test %0d %s funct3=%0d addr=%h: ok", i,
                     v_write[i] ? "store" : "load ", v_funct3[i], v_addr[i]);
        end else begin
            failed_tests++;
            $display("test %0d %s funct3=%0d addr=%h: failed", i,
                     v_write[i] ? "store" : "load ", v_funct3[i], v_addr[i]);
        end
    endtask

    // Watchdog of ten cycles per test plus the reset
    initial begin
        wait (loaded);
        #((n_tests * 10 + 3) * clk_period);
        $display("timeout: the run did not finish within %0d cycles", n_tests * 10 + 3);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req_write <= 1'b0;
        funct3    <= '0;
        req_addr  <= '0;
        req_data  <= '0;
        read_vectors();
        if (n_tests == 0) begin
            $display("no test vectors could be read from the stimulus file");
            $display("Test failures found");
        end else begin
            repeat (3) @(posedge clk);
            rst_n <= 1'b1;
            @(negedge clk);
            check_idle();
            for (int i = 0; i < n_tests; i++) begin
                run_access(i);
            end
            errors += dut_i.chk_i.assert_fails;
            $display("%0d tests run, %0d failed, %0d errors", n_tests, failed_tests, errors);
            if (errors == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
        end
        $finish;
    end

endmodule

//--- mem_access.f
src/rv_isa_pkg.sv
src/mem_bus_pkg.sv
src/access_if.sv
src/access_decode.sv
src/byte_lane.sv
src/load_merge.sv
src/mem_access_unit.sv
bench/mem_access_checker.sv
bench/mem_access_tb.sv

//--- src/access_decode.sv
`timescale 1ns/10ps

module access_decode #(
    parameter int DATA_WIDTH = mem_bus_pkg::default_data_width,
    parameter int ADDR_WIDTH = mem_bus_pkg::default_addr_width
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_valid,
    input  logic                                  req_write,
    input  logic [rv_isa_pkg::funct3_width-1:0]   funct3,
    input  logic [ADDR_WIDTH-1:0]                 req_addr,
    input  logic [DATA_WIDTH-1:0]                 req_data,
    output logic                                  mem_request,
    output logic                                  mem_write,
    output logic [ADDR_WIDTH-1:0]                 mem_addr,
    output logic                                  exception_valid,
    output logic [rv_isa_pkg::exc_code_width-1:0] exception_code,
    access_if.sender                              acc
);
    localparam int LANES = DATA_WIDTH / 8;
    localparam int OFFSET_WIDTH = $clog2(LANES);

    logic [mem_bus_pkg::lane_offset_width-1:0] low_addr;
    logic misaligned;
    logic illegal;
    logic error;

    assign low_addr = req_addr[mem_bus_pkg::lane_offset_width-1:0];

    // Natural alignment per size
    always_comb begin
        case (funct3[1:0])
            rv_isa_pkg::size_byte:   misaligned = 1'b0;
            rv_isa_pkg::size_half:   misaligned = low_addr[0];
            rv_isa_pkg::size_word:   misaligned = |low_addr[1:0];
            rv_isa_pkg::size_double: misaligned = |low_addr;
            default:                 misaligned = 1'b0;
        endcase
    end

    // No unsigned stores, no unsigned double, no double wider than the bus
    assign illegal = (funct3[2] && req_write) ||
                     (funct3[2] && funct3[1:0] == rv_isa_pkg::size_double) ||
                     (funct3[1:0] == rv_isa_pkg::size_double && DATA_WIDTH < 64);

    assign error = illegal || misaligned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_request     <= 1'b0;
            mem_write       <= 1'b0;
            acc.active      <= 1'b0;
            exception_valid <= 1'b0;
            exception_code  <= '0;
        end else begin
            mem_request     <= req_valid && !error;
            mem_write       <= req_valid && req_write && !error;
            acc.active      <= req_valid && !error;
            exception_valid <= req_valid && error;
            if (req_valid && error) begin
                exception_code <= req_write ? rv_isa_pkg::exc_store_misaligned
                                            : rv_isa_pkg::exc_load_misaligned;
            end
        end
    end

    // Held until the next request, the load result needs size and offset
    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem_addr        <= req_addr;
            acc.is_write    <= req_write;
            acc.size        <= mem_bus_pkg::access_size_t'(funct3[1:0]);
            acc.is_unsigned <= funct3[2];
            acc.offset      <= req_addr[OFFSET_WIDTH-1:0];
            acc.store_data  <= req_data;
        end
    end

endmodule

//--- src/access_if.sv
`timescale 1ns/10ps

interface access_if #(
    parameter int DATA_WIDTH = mem_bus_pkg::default_data_width
);
    localparam int LANES = DATA_WIDTH / 8;
    localparam int OFFSET_WIDTH = $clog2(LANES);

    logic                      active;
    logic                      is_write;
    mem_bus_pkg::access_size_t size;
    logic                      is_unsigned;
    logic [OFFSET_WIDTH-1:0]   offset;
    logic [DATA_WIDTH-1:0]     store_data;
    logic [DATA_WIDTH-1:0]     read_data;

    modport sender (
        output active, is_write, size, is_unsigned, offset, store_data
    );

    // Memory side, read data only
    modport bus (
        output read_data
    );

    modport receiver (
        input active, is_write, size, is_unsigned, offset, store_data, read_data
    );

endinterface

//--- src/byte_lane.sv
`timescale 1ns/10ps

module byte_lane #(
    parameter int DATA_WIDTH = mem_bus_pkg::default_data_width,
    parameter int LANE       = 0
) (
    access_if.receiver acc,
    output logic       strobe,
    output logic [7:0] store_byte,
    output logic [7:0] load_byte
);
    localparam int LANES = DATA_WIDTH / 8;

    int first;
    int last;
    int store_idx;
    int load_idx;

    // Lane inside [offset, offset + size)
    always_comb begin
        first  = int'(acc.offset);
        last   = first + (1 << int'(acc.size)) - 1;
        strobe = acc.active && (LANE >= first) && (LANE <= last);
    end

    // Store data shifted up by the offset
    always_comb begin
        store_idx = LANE - int'(acc.offset);
        if (acc.is_write && store_idx >= 0) begin
            store_byte = acc.store_data[8*store_idx +: 8];
        end else begin
            store_byte = '0;
        end
    end

    // Read data shifted down so the addressed byte lands in byte 0
    always_comb begin
        load_idx = LANE + int'(acc.offset);
        if (load_idx < LANES) begin
            load_byte = acc.read_data[8*load_idx +: 8];
        end else begin
            load_byte = '0;
        end
    end

endmodule

//--- src/load_merge.sv
`timescale 1ns/10ps

module load_merge #(
    parameter int DATA_WIDTH = mem_bus_pkg::default_data_width
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mem_read_valid,
    input  logic [DATA_WIDTH/8-1:0]      strobe,
    input  logic [DATA_WIDTH/8-1:0][7:0] store_byte,
    input  logic [DATA_WIDTH/8-1:0][7:0] load_byte,
    access_if.receiver                   acc,
    output logic [DATA_WIDTH/8-1:0]      mem_byte_en,
    output logic [DATA_WIDTH-1:0]        mem_data,
    output logic                         load_valid,
    output logic [DATA_WIDTH-1:0]        load_data
);
    localparam int LANES = DATA_WIDTH / 8;

    logic [8*LANES-1:0]    raw;
    logic [DATA_WIDTH-1:0] extended;
    logic                  sign;
    int                    nbits;

    assign mem_byte_en = strobe;
    assign mem_data    = store_byte;
    assign raw         = load_byte;

    always_comb begin
        case (acc.size)
            mem_bus_pkg::access_byte: sign = raw[7];
            mem_bus_pkg::access_half: sign = raw[15];
            mem_bus_pkg::access_word: sign = raw[31];
            default:                  sign = raw[DATA_WIDTH-1];
        endcase
    end

    // Keep the addressed bytes, fill the rest with sign or zero
    always_comb begin
        nbits = 8 << int'(acc.size);
        for (int i = 0; i < DATA_WIDTH; i++) begin
            extended[i] = (i < nbits) ? raw[i] : (sign && !acc.is_unsigned);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= mem_read_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_read_valid) begin
            load_data <= extended;
        end
    end

endmodule

//--- src/mem_access_unit.sv
`timescale 1ns/10ps

module mem_access_unit #(
    parameter int DATA_WIDTH = mem_bus_pkg::default_data_width,
    parameter int ADDR_WIDTH = mem_bus_pkg::default_addr_width
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_valid,
    input  logic                                  req_write,
    input  logic [rv_isa_pkg::funct3_width-1:0]   funct3,
    input  logic [ADDR_WIDTH-1:0]                 req_addr,
    input  logic [DATA_WIDTH-1:0]                 req_data,
    output logic                                  mem_request,
    output logic                                  mem_write,
    output logic [ADDR_WIDTH-1:0]                 mem_addr,
    output logic [DATA_WIDTH/8-1:0]               mem_byte_en,
    output logic [DATA_WIDTH-1:0]                 mem_data,
    input  logic                                  mem_read_valid,
    input  logic [DATA_WIDTH-1:0]                 mem_read_data,
    output logic                                  exception_valid,
    output logic [rv_isa_pkg::exc_code_width-1:0] exception_code,
    output logic                                  load_valid,
    output logic [DATA_WIDTH-1:0]                 load_data
);
    localparam int LANES = DATA_WIDTH / 8;

    logic [LANES-1:0]      lane_strobe;
    logic [LANES-1:0][7:0] lane_store;
    logic [LANES-1:0][7:0] lane_load;

    access_if #(.DATA_WIDTH(DATA_WIDTH)) acc ();

    assign acc.read_data = mem_read_data;

    access_decode #(
        .DATA_WIDTH(DATA_WIDTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) decode_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .funct3         (funct3),
        .req_addr       (req_addr),
        .req_data       (req_data),
        .mem_request    (mem_request),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .exception_valid(exception_valid),
        .exception_code (exception_code),
        .acc            (acc)
    );

    // One lane per byte of the bus
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        byte_lane #(
            .DATA_WIDTH(DATA_WIDTH),
            .LANE      (i)
        ) lane_i (
            .acc       (acc),
            .strobe    (lane_strobe[i]),
            .store_byte(lane_store[i]),
            .load_byte (lane_load[i])
        );
    end

    load_merge #(
        .DATA_WIDTH(DATA_WIDTH)
    ) merge_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_read_valid(mem_read_valid),
        .strobe        (lane_strobe),
        .store_byte    (lane_store),
        .load_byte     (lane_load),
        .acc           (acc),
        .mem_byte_en   (mem_byte_en),
        .mem_data      (mem_data),
        .load_valid    (load_valid),
        .load_data     (load_data)
    );

endmodule

//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

    // Bus geometry defaults
    localparam int default_data_width = 64;
    localparam int default_addr_width = 64;

    // Low address bits that pick a byte lane on a 64-bit bus
    localparam int lane_offset_width = 3;

    // Same encoding as funct3 bits 1 to 0
    typedef enum logic [1:0] {
        access_byte   = rv_isa_pkg::size_byte,
        access_half   = rv_isa_pkg::size_half,
        access_word   = rv_isa_pkg::size_word,
        access_double = rv_isa_pkg::size_double
    } access_size_t;

endpackage

//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // funct3 of loads and stores, bit 2 marks an unsigned load
    localparam int funct3_width = 3;

    // Access size in funct3 bits 1 to 0
    localparam logic [1:0] size_byte   = 2'b00;
    localparam logic [1:0] size_half   = 2'b01;
    localparam logic [1:0] size_word   = 2'b10;
    localparam logic [1:0] size_double = 2'b11;

    localparam int exc_code_width = 4;

    // Synchronous exception causes (mcause)
    localparam logic [exc_code_width-1:0] exc_load_misaligned  = 4'd4;
    localparam logic [exc_code_width-1:0] exc_store_misaligned = 4'd6;

endpackage
